//--- src/rv_defines.svh
// rv64i core constants: reset pc, memory map, csr addresses and funct3 codes
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RESET_PC        64'h0000_0000_8000_0000
`define DMEM_WORDS_LOG2 8
`define DMEM_BASE       64'h0000_0000_8000_1000
// 4 KiB window, stores here are dropped
`define DEVICE_BASE     64'h0000_0000_2000_0000

`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVEC       12'h305
`define CSR_MCYCLE      12'hb00

// loads and stores, low two bits give the access size
`define FUNCT3_LB       3'b000
`define FUNCT3_LH       3'b001
`define FUNCT3_LW       3'b010
`define FUNCT3_LD       3'b011
`define FUNCT3_SB       3'b000
`define FUNCT3_SH       3'b001
`define FUNCT3_SW       3'b010
`define FUNCT3_SD       3'b011

`define FUNCT3_BEQ      3'b000
`define FUNCT3_BNE      3'b001
`define FUNCT3_BLT      3'b100
`define FUNCT3_BGE      3'b101
`define FUNCT3_BLTU     3'b110
`define FUNCT3_BGEU     3'b111

// op and op-imm, sll/srl double as the shift codes
`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SRL      3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

`define FUNCT3_CSRRW    3'b001
`define FUNCT3_CSRRS    3'b010
`define FUNCT3_CSRRC    3'b011
`define FUNCT3_CSRRWI   3'b101
`define FUNCT3_CSRRSI   3'b110
`define FUNCT3_CSRRCI   3'b111

`endif

//--- src/rv_pkg.sv
// rv64i core shared types: data words, opcodes, formats, alu and csr operations
package rv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  // major opcode, inst[6:2]
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_fence  = 5'b00011,
    op_imm    = 5'b00100,
    op_auipc  = 5'b00101,
    op_imm_w  = 5'b00110,
    op_store  = 5'b01000,
    op_reg    = 5'b01100,
    op_lui    = 5'b01101,
    op_reg_w  = 5'b01110,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011,
    op_system = 5'b11100
  } opcode_e;

  typedef enum logic [2:0] {
    fmt_none, fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j
  } itype_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    csr_none, csr_write, csr_set, csr_clear
  } csr_op_e;

endpackage

//--- src/id_stage.sv
// instruction decode: fields, immediates, operands, memory and csr controls
`timescale 1ns/1ps
`include "rv_defines.svh"

module id_stage (
  input  rv_pkg::inst_t     inst,
  input  rv_pkg::xlen_t     pc,
  input  rv_pkg::xlen_t     rs1_data,
  input  rv_pkg::xlen_t     rs2_data,
  output rv_pkg::reg_idx_t  rs1,
  output rv_pkg::reg_idx_t  rs2,
  output rv_pkg::reg_idx_t  rd,
  output logic              rs1_ren,
  output logic              rs2_ren,
  output logic              rd_wen,
  output rv_pkg::itype_e    itype,
  output rv_pkg::opcode_e   opcode,
  output logic [2:0]        funct3,
  output rv_pkg::alu_op_e   alu_op,
  output logic              word_op,
  output logic              is_branch,
  output logic              is_jump,
  output rv_pkg::xlen_t     op1,
  output rv_pkg::xlen_t     op2,
  output rv_pkg::xlen_t     t1,
  output logic              mem_ren,
  output logic              mem_wen,
  output logic [1:0]        mem_size,
  output logic              mem_unsigned,
  output rv_pkg::xlen_t     mem_addr,
  output rv_pkg::xlen_t     mem_wdata,
  output rv_pkg::csr_addr_t csr_addr,
  output rv_pkg::csr_op_e   csr_op,
  output rv_pkg::xlen_t     csr_wdata,
  output logic              skip
);
  import rv_pkg::*;

  xlen_t imm;
  xlen_t shamt;
  xlen_t zimm;
  logic  is_arith;
  logic  is_reg_form;
  logic  is_shift;
  logic  alt_op;
  logic  mem_is_device;

  assign opcode = opcode_e'(inst[6:2]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  // inst[30] picks sub and sra
  assign alt_op = inst[30];
  assign shamt  = {58'd0, inst[25:20]};
  assign zimm   = {59'd0, inst[19:15]};

  always_comb begin
    case (opcode)
      op_lui, op_auipc:                              itype = fmt_u;
      op_jal:                                        itype = fmt_j;
      op_jalr, op_load, op_imm, op_imm_w, op_fence: itype = fmt_i;
      op_system:                                     itype = fmt_i;
      op_branch:                                     itype = fmt_b;
      op_store:                                      itype = fmt_s;
      op_reg, op_reg_w:                              itype = fmt_r;
      default:                                       itype = fmt_none;
    endcase
  end

  // sign-extended immediate per format
  always_comb begin
    case (itype)
      fmt_i:   imm = {{52{inst[31]}}, inst[31:20]};
      fmt_s:   imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      fmt_b:   imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      fmt_u:   imm = {{32{inst[31]}}, inst[31:12], 12'd0};
      fmt_j:   imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  assign rs1_ren = (itype == fmt_r) || (itype == fmt_i) || (itype == fmt_s) ||
                   (itype == fmt_b);
  assign rs2_ren = (itype == fmt_r) || (itype == fmt_s) || (itype == fmt_b);

  always_comb begin
    case (itype)
      fmt_r, fmt_u, fmt_j: rd_wen = (rd != '0);
      // fence and ecall/ebreak write nothing
      fmt_i:   rd_wen = (rd != '0) && (opcode != op_fence) &&
                        ((opcode != op_system) || (csr_op != csr_none));
      default: rd_wen = 1'b0;
    endcase
  end

  assign is_reg_form = (opcode == op_reg) || (opcode == op_reg_w);
  assign is_arith    = is_reg_form || (opcode == op_imm) || (opcode == op_imm_w);
  assign is_shift    = (opcode == op_imm || opcode == op_imm_w) &&
                       (funct3 == `FUNCT3_SLL || funct3 == `FUNCT3_SRL);
  assign word_op     = (opcode == op_imm_w) || (opcode == op_reg_w);
  assign is_branch   = (opcode == op_branch);
  assign is_jump     = (opcode == op_jal) || (opcode == op_jalr);

  always_comb begin
    alu_op = alu_add;
    if (opcode == op_jal) begin
      alu_op = alu_pass_b;
    end else if (is_arith) begin
      case (funct3)
        `FUNCT3_ADD:  alu_op = (alt_op && is_reg_form) ? alu_sub : alu_add;
        `FUNCT3_SLL:  alu_op = alu_sll;
        `FUNCT3_SLT:  alu_op = alu_slt;
        `FUNCT3_SLTU: alu_op = alu_sltu;
        `FUNCT3_XOR:  alu_op = alu_xor;
        `FUNCT3_SRL:  alu_op = alt_op ? alu_sra : alu_srl;
        `FUNCT3_OR:   alu_op = alu_or;
        default:      alu_op = alu_and;
      endcase
    end
  end

  // jal carries link in op1 and target in op2
  always_comb begin
    op1 = rs1_data;
    op2 = imm;
    case (itype)
      fmt_r, fmt_b: op2 = rs2_data;
      fmt_i: begin
        if (is_shift) begin
          op2 = shamt;
        end
      end
      fmt_j: begin
        op1 = pc + 64'd4;
        op2 = pc + imm;
      end
      fmt_u: begin
        op1 = (opcode == op_lui) ? imm : pc;
        op2 = (opcode == op_auipc) ? imm : '0;
      end
      default: op2 = imm;
    endcase
  end

  // branch target, or link address for jumps
  assign t1 = is_branch ? pc + imm : (is_jump ? pc + 64'd4 : '0);

  assign mem_ren      = (opcode == op_load);
  assign mem_wen      = (opcode == op_store);
  assign mem_size     = funct3[1:0];
  assign mem_unsigned = funct3[2];
  assign mem_addr     = rs1_data + imm;
  assign mem_wdata    = rs2_data;

  always_comb begin
    csr_op = csr_none;
    if (opcode == op_system) begin
      case (funct3)
        `FUNCT3_CSRRW, `FUNCT3_CSRRWI: csr_op = csr_write;
        `FUNCT3_CSRRS, `FUNCT3_CSRRSI: csr_op = csr_set;
        `FUNCT3_CSRRC, `FUNCT3_CSRRCI: csr_op = csr_clear;
        default:                       csr_op = csr_none;
      endcase
    end
  end

  assign csr_addr  = inst[31:20];
  assign csr_wdata = funct3[2] ? zimm : rs1_data;

  assign mem_is_device = (mem_ren || mem_wen) && ((mem_addr & ~64'hfff) == `DEVICE_BASE);
  assign skip          = (csr_op != csr_none) || mem_is_device;

endmodule

//--- src/regfile.sv
// integer register file, 32 x 64 bits, x0 reads as zero
`timescale 1ns/1ps

module regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  logic             wen,
  input  rv_pkg::xlen_t    wdata,
  output rv_pkg::xlen_t    rs1_data,
  output rv_pkg::xlen_t    rs2_data
);
  import rv_pkg::*;

  // x1..x31 only
  xlen_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- src/exe_stage.sv
// execute: alu with 32-bit word forms, branch compare and next pc
`timescale 1ns/1ps
`include "rv_defines.svh"

module exe_stage (
  input  rv_pkg::xlen_t   op1,
  input  rv_pkg::xlen_t   op2,
  input  rv_pkg::xlen_t   t1,
  input  rv_pkg::xlen_t   pc,
  input  rv_pkg::alu_op_e alu_op,
  input  logic            word_op,
  input  logic            is_branch,
  input  logic            is_jump,
  input  logic [2:0]      funct3,
  output rv_pkg::xlen_t   alu_result,
  output rv_pkg::xlen_t   next_pc,
  output logic            taken
);
  import rv_pkg::*;

  xlen_t       full_res;
  logic [31:0] word_res;
  logic [31:0] op1_w;
  logic [31:0] op2_w;
  logic        cond;
  logic        br_taken;
  xlen_t       jump_target;

  assign op1_w = op1[31:0];
  assign op2_w = op2[31:0];

  always_comb begin
    case (alu_op)
      alu_add:    full_res = op1 + op2;
      alu_sub:    full_res = op1 - op2;
      alu_sll:    full_res = op1 << op2[5:0];
      alu_slt:    full_res = {63'd0, $signed(op1) < $signed(op2)};
      alu_sltu:   full_res = {63'd0, op1 < op2};
      alu_xor:    full_res = op1 ^ op2;
      alu_srl:    full_res = op1 >> op2[5:0];
      alu_sra:    full_res = $signed(op1) >>> op2[5:0];
      alu_or:     full_res = op1 | op2;
      alu_and:    full_res = op1 & op2;
      default:    full_res = op2;
    endcase
  end

  // word forms shift by 5 bits only
  always_comb begin
    case (alu_op)
      alu_add: word_res = op1_w + op2_w;
      alu_sub: word_res = op1_w - op2_w;
      alu_sll: word_res = op1_w << op2[4:0];
      alu_srl: word_res = op1_w >> op2[4:0];
      alu_sra: word_res = $signed(op1_w) >>> op2[4:0];
      default: word_res = full_res[31:0];
    endcase
  end

  assign alu_result = word_op ? {{32{word_res[31]}}, word_res} : full_res;

  always_comb begin
    case (funct3)
      `FUNCT3_BEQ:  cond = (op1 == op2);
      `FUNCT3_BNE:  cond = (op1 != op2);
      `FUNCT3_BLT:  cond = ($signed(op1) < $signed(op2));
      `FUNCT3_BGE:  cond = ($signed(op1) >= $signed(op2));
      `FUNCT3_BLTU: cond = (op1 < op2);
      `FUNCT3_BGEU: cond = (op1 >= op2);
      default:      cond = 1'b0;
    endcase
  end

  assign br_taken    = is_branch && cond;
  // jalr clears bit 0, jal target is already even
  assign jump_target = {alu_result[63:1], 1'b0};
  // redirect away from the sequential pc
  assign taken       = br_taken || is_jump;
  assign next_pc     = br_taken ? t1 : (is_jump ? jump_target : pc + 64'd4);

endmodule

//--- src/data_mem.sv
// data memory, byte addressed, sized loads with extension and masked stores
`timescale 1ns/1ps
`include "rv_defines.svh"

module data_mem (
  input  logic          clk,
  input  logic          ren,
  input  logic          wen,
  input  rv_pkg::xlen_t addr,
  input  logic [1:0]    size,
  input  logic          is_unsigned,
  input  rv_pkg::xlen_t wdata,
  output rv_pkg::xlen_t rdata
);
  import rv_pkg::*;

  localparam int DEPTH = 2 ** `DMEM_WORDS_LOG2;

  xlen_t                       mem [DEPTH];
  xlen_t                       offset;
  logic [`DMEM_WORDS_LOG2-1:0] word_idx;
  logic [5:0]                  lane_shift;
  xlen_t                       raw;
  xlen_t                       loaded;
  logic [7:0]                  byte_mask;
  xlen_t                       bit_mask;
  logic                        is_device;

  assign offset     = addr - `DMEM_BASE;
  assign word_idx   = offset[`DMEM_WORDS_LOG2+2:3];
  assign lane_shift = {addr[2:0], 3'b000};
  // addressed byte moved down to bit 0
  assign raw        = mem[word_idx] >> lane_shift;
  assign is_device  = (addr & ~64'hfff) == `DEVICE_BASE;

  always_comb begin
    case ({1'b0, size})
      `FUNCT3_LB: loaded = is_unsigned ? {56'd0, raw[7:0]} : {{56{raw[7]}}, raw[7:0]};
      `FUNCT3_LH: loaded = is_unsigned ? {48'd0, raw[15:0]} : {{48{raw[15]}}, raw[15:0]};
      `FUNCT3_LW: loaded = is_unsigned ? {32'd0, raw[31:0]} : {{32{raw[31]}}, raw[31:0]};
      `FUNCT3_LD: loaded = raw;
      default:    loaded = raw;
    endcase
  end

  assign rdata = ren ? loaded : '0;

  always_comb begin
    case ({1'b0, size})
      `FUNCT3_SB: byte_mask = 8'h01 << addr[2:0];
      `FUNCT3_SH: byte_mask = 8'h03 << addr[2:0];
      `FUNCT3_SW: byte_mask = 8'h0f << addr[2:0];
      `FUNCT3_SD: byte_mask = 8'hff;
      default:    byte_mask = 8'h00;
    endcase
    for (int b = 0; b < 8; b++) begin
      bit_mask[b*8 +: 8] = {8{byte_mask[b]}};
    end
  end

  // device window stores are dropped
  always_ff @(posedge clk) begin
    if (wen && !is_device) begin
      mem[word_idx] <= (mem[word_idx] & ~bit_mask) | ((wdata << lane_shift) & bit_mask);
    end
  end

endmodule

//--- src/csr_file.sv
// machine csrs with write/set/clear and a free-running cycle counter
`timescale 1ns/1ps
`include "rv_defines.svh"

module csr_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              accept,
  input  rv_pkg::csr_addr_t csr_addr,
  input  rv_pkg::csr_op_e   csr_op,
  input  rv_pkg::xlen_t     csr_wdata,
  output rv_pkg::xlen_t     csr_rdata
);
  import rv_pkg::*;

  xlen_t mscratch;
  xlen_t mepc;
  xlen_t mcause;
  xlen_t mtvec;
  xlen_t mcycle;
  xlen_t next_val;

  always_comb begin
    case (csr_addr)
      `CSR_MSCRATCH: csr_rdata = mscratch;
      `CSR_MEPC:     csr_rdata = mepc;
      `CSR_MCAUSE:   csr_rdata = mcause;
      `CSR_MTVEC:    csr_rdata = mtvec;
      `CSR_MCYCLE:   csr_rdata = mcycle;
      default:       csr_rdata = '0;
    endcase
  end

  // read-modify-write value
  always_comb begin
    case (csr_op)
      csr_write: next_val = csr_wdata;
      csr_set:   next_val = csr_rdata | csr_wdata;
      csr_clear: next_val = csr_rdata & ~csr_wdata;
      default:   next_val = csr_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtvec    <= '0;
      mcycle   <= '0;
    end else begin
      // counts through bubbles too
      mcycle <= mcycle + 64'd1;
      if (accept && (csr_op != csr_none)) begin
        case (csr_addr)
          `CSR_MSCRATCH: mscratch <= next_val;
          `CSR_MEPC:     mepc     <= next_val;
          `CSR_MCAUSE:   mcause   <= next_val;
          `CSR_MTVEC:    mtvec    <= next_val;
          default:       ;
        endcase
      end
    end
  end

endmodule

//--- src/rv_core.sv
// single-cycle rv64i core top: pc register, writeback select and stage wiring
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::inst_t    inst,
  input  logic             inst_valid,
  output rv_pkg::xlen_t    pc,
  output rv_pkg::xlen_t    commit_pc,
  output rv_pkg::xlen_t    commit_wdata,
  output logic             commit_valid,
  output logic             commit_wen,
  output rv_pkg::reg_idx_t commit_rd,
  output logic             skip
);
  import rv_pkg::*;

  logic      accept;
  reg_idx_t  rs1, rs2, rd, rf_rs1, rf_rs2;
  logic      rs1_ren, rs2_ren, rd_wen, word_op, is_branch, is_jump, taken;
  itype_e    itype;
  opcode_e   opcode;
  logic [2:0] funct3;
  alu_op_e   alu_op;
  xlen_t     rs1_data, rs2_data, op1, op2, t1, alu_result, next_pc;
  logic      mem_ren, mem_wen, mem_unsigned, id_skip;
  logic [1:0] mem_size;
  xlen_t     mem_addr, mem_wdata, load_data;
  csr_addr_t csr_addr;
  csr_op_e   csr_op;
  xlen_t     csr_wdata, csr_rdata, wb_data;

  assign accept = inst_valid && !rst;
  // unread ports index x0
  assign rf_rs1 = rs1_ren ? rs1 : '0;
  assign rf_rs2 = rs2_ren ? rs2 : '0;

  id_stage u_id (.inst, .pc, .rs1_data, .rs2_data, .rs1, .rs2, .rd, .rs1_ren, .rs2_ren,
    .rd_wen, .itype, .opcode, .funct3, .alu_op, .word_op, .is_branch, .is_jump, .op1, .op2,
    .t1, .mem_ren, .mem_wen, .mem_size, .mem_unsigned, .mem_addr, .mem_wdata, .csr_addr,
    .csr_op, .csr_wdata, .skip(id_skip));

  regfile u_rf (.clk, .rst, .rs1(rf_rs1), .rs2(rf_rs2), .rd, .wen(accept && rd_wen),
    .wdata(wb_data), .rs1_data, .rs2_data);

  exe_stage u_exe (.op1, .op2, .t1, .pc, .alu_op, .word_op, .is_branch, .is_jump, .funct3,
    .alu_result, .next_pc, .taken);

  data_mem u_dmem (.clk, .ren(accept && mem_ren), .wen(accept && mem_wen), .addr(mem_addr),
    .size(mem_size), .is_unsigned(mem_unsigned), .wdata(mem_wdata), .rdata(load_data));

  csr_file u_csr (.clk, .rst, .accept, .csr_addr, .csr_op, .csr_wdata, .csr_rdata);

  // link address sits in t1 for jal and jalr
  always_comb begin
    if (opcode == op_load) begin
      wb_data = load_data;
    end else if (opcode == op_system) begin
      wb_data = csr_rdata;
    end else if ((itype == fmt_j) || (opcode == op_jalr)) begin
      wb_data = t1;
    end else begin
      wb_data = alu_result;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (inst_valid) begin
      pc <= taken ? next_pc : pc + 64'd4;
    end
  end

  assign commit_valid = accept;
  assign commit_pc    = pc;
  assign commit_wen   = accept && rd_wen;
  assign commit_rd    = rd;
  assign commit_wdata = wb_data;
  assign skip         = accept && id_skip;

endmodule

//--- sim/tb_clock.sv
// testbench clock source with a fixed period
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

//--- sim/rv_core_assertions.sv
// concurrent checks on the core's commit port and program counter
`timescale 1ns/1ps

module rv_core_assertions (
  input logic          clk,
  input logic          rst,
  input logic          inst_valid,
  input logic          commit_valid,
  input logic          commit_wen,
  input rv_pkg::xlen_t pc
);

  // a register write only comes with a commit
  wen_needs_valid: assert property (@(posedge clk) commit_wen |-> commit_valid)
    else $error("commit_wen high while commit_valid is low");

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc is not 4-byte aligned: %h", pc);

  // bubble cycles leave the pc alone
  pc_holds_on_bubble: assert property (
    @(posedge clk) disable iff (rst) !inst_valid |=> $stable(pc)
  ) else $error("pc changed across a cycle without inst_valid");

endmodule

bind rv_core rv_core_assertions u_assertions (
  .clk,
  .rst,
  .inst_valid,
  .commit_valid,
  .commit_wen,
  .pc
);

//--- sim/rv_core_tb.sv
// rv64i core testbench that replays recorded instructions and checks each commit
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_tb;
  import rv_pkg::*;

  // pc, inst, gap, wen, rd, wdata, skip
  localparam int FIELDS      = 7;
  localparam int MAX_RECORDS = 64;

  logic     clk;
  logic     rst;
  inst_t    inst;
  logic     inst_valid;
  xlen_t    pc;
  xlen_t    commit_pc;
  xlen_t    commit_wdata;
  logic     commit_valid;
  logic     commit_wen;
  reg_idx_t commit_rd;
  logic     skip;

  xlen_t  stim [FIELDS*MAX_RECORDS];
  int     num_records;
  int     cycle_count;
  int     timeout_limit;
  integer seed;

  tb_clock u_clock (.clk);

  rv_core dut0 (
    .clk, .rst, .inst, .inst_valid, .pc, .commit_pc, .commit_wdata,
    .commit_valid, .commit_wen, .commit_rd, .skip
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, expected));
    end
  endtask

  initial begin
    int    base;
    int    gap;
    xlen_t exp_pc;

    rst           = 1'b1;
    inst          = '0;
    inst_valid    = 1'b0;
    seed          = 32'h9be6;
    num_records   = 0;
    timeout_limit = 0;

    // upper half all ones marks an empty slot
    for (int i = 0; i < FIELDS * MAX_RECORDS; i++) begin
      stim[i] = {32'hffff_ffff, 32'(i)};
    end
    $readmemh("sim/rv_core_stimulus.txt", stim);
    while (num_records < MAX_RECORDS &&
           stim[num_records*FIELDS][63:32] != 32'hffff_ffff) begin
      num_records++;
    end
    if (num_records == 0) begin
      stop_with_failure("stimulus file is missing or holds no records");
    end
    timeout_limit = num_records * 9 + 20;

    repeat (3) @(posedge clk);
    // a valid instruction under reset commits nothing and leaves the pc
    @(negedge clk);
    inst       = stim[1][31:0];
    inst_valid = 1'b1;
    #10;
    check_word("pc", pc, `RESET_PC);
    check_flag("commit_valid", commit_valid, 1'b0);
    check_flag("commit_wen", commit_wen, 1'b0);
    @(negedge clk);
    inst_valid = 1'b0;
    inst       = '0;
    check_word("pc", pc, `RESET_PC);
    rst = 1'b0;

    for (int r = 0; r < num_records; r++) begin
      base   = r * FIELDS;
      exp_pc = stim[base];
      if (stim[base+2][7:0] == 8'hff) begin
        gap = $random(seed) & 3;
      end else begin
        gap = int'(stim[base+2][7:0]);
      end
      // bubbles hold the pc
      repeat (gap) begin
        @(negedge clk);
        inst_valid = 1'b0;
        inst       = '0;
        #10;
        check_flag("commit_valid", commit_valid, 1'b0);
        check_word("pc", pc, exp_pc);
      end
      @(negedge clk);
      inst       = stim[base+1][31:0];
      inst_valid = 1'b1;
      #10;
      check_flag("commit_valid", commit_valid, 1'b1);
      check_word("pc", pc, exp_pc);
      check_word("commit_pc", commit_pc, exp_pc);
      check_flag("commit_wen", commit_wen, stim[base+3][0]);
      if (stim[base+3][0]) begin
        check_reg("commit_rd", commit_rd, stim[base+4][4:0]);
        check_word("commit_wdata", commit_wdata, stim[base+5]);
      end
      check_flag("skip", skip, stim[base+6][0]);
    end

    @(negedge clk);
    inst_valid = 1'b0;
    inst       = '0;
    $display("STATUS: PASS");
    $finish;
  end

  // cycle budget covers reset, bubbles and one cycle per record
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (timeout_limit > 0 && cycle_count > timeout_limit) begin
        $display("timeout, no verdict after %0d cycles", cycle_count);
        $display("STATUS: FAIL");
        $fatal(1, "run exceeded its cycle limit");
      end
    end
  end

endmodule

//--- sim/rv_core_stimulus.txt
// columns: pc inst gap wen rd wdata skip, one record per executed instruction
// gap counts bubble cycles before the instruction, ff asks for a random count
80000000 00001297 03 1 05 0000000080001000 0
80000004 ffb00093 00 1 01 fffffffffffffffb 0
80000008 07f00113 ff 1 02 000000000000007f 0
8000000c 002081b3 01 1 03 000000000000007a 0
80000010 40208233 00 1 04 ffffffffffffff7c 0
80000014 03c11393 ff 1 07 f000000000000000 0
80000018 4043d413 00 1 08 ff00000000000000 0
8000001c 0043d493 02 1 09 0f00000000000000 0
80000020 0020a533 00 1 0a 0000000000000001 0
80000024 00108013 ff 0 00 0000000000000000 0
80000028 002007b3 00 1 0f 000000000000007f 0
8000002c 7ffff8b7 01 1 11 000000007ffff000 0
80000030 7ff8881b 00 1 10 000000007ffff7ff 0
80000034 0108093b ff 1 12 ffffffffffffeffe 0
80000038 410009bb 00 1 13 ffffffff80000801 0
8000003c 00481a1b 00 1 14 ffffffffffff7ff0 0
80000040 4089da9b 02 1 15 ffffffffff800008 0
80000044 0132b023 00 0 00 0000000000000000 0
80000048 002280a3 ff 0 00 0000000000000000 0
8000004c 00429223 00 0 00 0000000000000000 0
80000050 20000337 01 1 06 0000000020000000 0
80000054 00233023 00 0 00 0000000000000000 1
80000058 0002bc03 ff 1 18 ffffff7c80007f01 0
8000005c 00328c83 00 1 19 ffffffffffffff80 0
80000060 0032cd03 00 1 1a 0000000000000080 0
80000064 00429d83 01 1 1b ffffffffffffff7c 0
80000068 0022de03 00 1 1c 0000000000008000 0
8000006c 0002ae83 ff 1 1d ffffffff80007f01 0
80000070 0042ef03 00 1 1e 00000000ffffff7c 0
80000074 00f19463 00 0 00 0000000000000000 0
8000007c 00f18863 02 0 00 0000000000000000 0
80000080 0000c663 00 0 00 0000000000000000 0
8000008c 34011573 ff 1 0a 0000000000000000 1
80000090 3401b5f3 00 1 0b 000000000000007f 1
80000094 340c6673 01 1 0c 0000000000000005 1
80000098 340026f3 00 1 0d 000000000000001d 1
8000009c 00c000ef ff 1 01 00000000800000a0 0
800000a8 01108f67 00 1 1e 00000000800000ac 0
800000b0 0ff0000f 01 0 00 0000000000000000 0

//--- rv_core.f
+incdir+src
src/rv_pkg.sv
src/id_stage.sv
src/regfile.sv
src/exe_stage.sv
src/data_mem.sv
src/csr_file.sv
src/rv_core.sv
sim/tb_clock.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv

//--- Makefile
TOP := rv_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f rv_core.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
